// ==== compile.f ====
hdl/harBnnPkg.sv
hdl/featureLoader.sv
hdl/sampleCounter.sv
hdl/inferenceCtrl.sv
hdl/bnnParser.sv
hdl/argmaxSelect.sv
hdl/harClassifier.sv
dv/harClassifierTb.sv

// ==== Makefile ====
TOP = harClassifierTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== dv/harClassifierTb.sv ====
`timescale 1ns/1ps

module harClassifierTb;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_FRAMES = 200;
    localparam int BURST_FRAMES = 10;
    localparam int DROP_FRAMES = 5;
    // Directed, random, burst, drop, plus partial and full frame around the late reset
    localparam int FRAME_TOTAL = 2 + RANDOM_FRAMES + BURST_FRAMES + DROP_FRAMES + 2;
    localparam int CYCLES_PER_FRAME = harBnnPkg::FEAT_CNT * 4 + 3;
    localparam int WATCHDOG_NS = FRAME_TOTAL * CYCLES_PER_FRAME * CLK_PERIOD
                                 + RESET_CYCLES * CLK_PERIOD;

    logic                            clk;
    logic                            rstN;
    logic                            featValid;
    logic [harBnnPkg::FEAT_BITS-1:0] featData;
    logic                            busy;
    logic                            predValid;
    harBnnPkg::predictionT           prediction;

    logic [31:0]           lcgState;
    int                    cycleCnt;
    int                    sentCount;
    int                    matchCount;
    harBnnPkg::predictionT expQ[$];
    int                    cycQ[$];

    harClassifier UUT (
        .clk        (clk),
        .rstN       (rstN),
        .featValid  (featValid),
        .featData   (featData),
        .busy       (busy),
        .predValid  (predValid),
        .prediction (prediction)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    task automatic abortRun();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            abortRun();
        end
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {16'd0, lcgState[30:15]};   // Upper bits since low ones cycle too fast
    endfunction

    function automatic harBnnPkg::featFrameT randomFrame();
        harBnnPkg::featFrameT f;
        for (int i = 0; i < harBnnPkg::FEAT_CNT; i++) begin
            f[i] = harBnnPkg::FEAT_BITS'(nextRand());
        end
        return f;
    endfunction

    // Signed add/subtract hidden layer, XNOR popcount and first max wins
    function automatic harBnnPkg::predictionT predictRef(input harBnnPkg::featFrameT f);
        logic [harBnnPkg::HIDDEN_CNT-1:0] hid;
        int acc;
        int score;
        int bestScore;
        int bestIdx;
        harBnnPkg::predictionT p;
        bestScore = -1;
        bestIdx = 0;
        for (int n = 0; n < harBnnPkg::HIDDEN_CNT; n++) begin
            acc = 0;
            for (int j = 0; j < harBnnPkg::FEAT_CNT; j++) begin
                if (harBnnPkg::WEIGHTS0[n * harBnnPkg::FEAT_CNT + j]) begin
                    acc = acc + int'(f[j]);
                end else begin
                    acc = acc - int'(f[j]);
                end
            end
            hid[n] = (acc >= 0);
        end
        for (int c = 0; c < harBnnPkg::CLASS_CNT; c++) begin
            score = 0;
            for (int h = 0; h < harBnnPkg::HIDDEN_CNT; h++) begin
                if (hid[h] == harBnnPkg::WEIGHTS1[c * harBnnPkg::HIDDEN_CNT + h]) begin
                    score = score + 1;
                end
            end
            if (score > bestScore) begin
                bestScore = score;
                bestIdx = c;
            end
        end
        p.classIdx = harBnnPkg::CLASS_BITS'(bestIdx);
        p.topScore = harBnnPkg::SUM_BITS'(bestScore);
        return p;
    endfunction

    task automatic driveCycle(input logic valid, input logic [harBnnPkg::FEAT_BITS-1:0] data);
        @(posedge clk);
        #DRIVE_DELAY;
        featValid = valid;
        featData = data;
    endtask

    // Streams one frame, then spends the INFER cycle with or without a stray pulse
    task automatic sendFrame(input harBnnPkg::featFrameT f, input bit useGaps,
                             input bit dropInInfer);
        int gap;
        for (int i = 0; i < harBnnPkg::FEAT_CNT; i++) begin
            gap = useGaps ? int'(nextRand() % 32'd4) : 0;
            repeat (gap) driveCycle(1'b0, '0);
            driveCycle(1'b1, f[i]);
        end
        expQ.push_back(predictRef(f));
        cycQ.push_back(cycleCnt + 2);   // Pulse in the second cycle after the sampling edge
        sentCount++;
        if (dropInInfer) begin
            driveCycle(1'b1, harBnnPkg::FEAT_BITS'(nextRand()));
        end else begin
            driveCycle(1'b0, '0);
        end
        checkValue("busy", 32'(busy), 1);
        if (dropInInfer) begin
            driveCycle(1'b0, '0);   // Stray pulse lasts the INFER cycle only
        end
    endtask

    task automatic waitDrain();
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic applyReset(input int cycles);
        @(posedge clk);
        #DRIVE_DELAY;
        rstN = 1'b0;
        featValid = 1'b0;
        repeat (cycles) @(posedge clk);
        #DRIVE_DELAY;
        rstN = 1'b1;
    endtask

    initial begin : compareProc
        harBnnPkg::predictionT expPred;
        int expCycle;
        forever begin
            @(negedge clk);
            if (predValid === 1'b1) begin
                if (expQ.size() == 0) begin
                    $display("Prediction pulse at %0t ns with no frame outstanding", $time);
                    abortRun();
                end else begin
                    expPred = expQ.pop_front();
                    expCycle = cycQ.pop_front();
                    checkValue("prediction.classIdx", 32'(prediction.classIdx),
                               32'(expPred.classIdx));
                    checkValue("prediction.topScore", 32'(prediction.topScore),
                               32'(expPred.topScore));
                    checkValue("predValid cycle", cycleCnt, expCycle);
                    matchCount++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the predictions did not arrive in time", WATCHDOG_NS);
        abortRun();
    end

    initial begin : stimulus
        harBnnPkg::featFrameT f;
        harBnnPkg::predictionT zeroRef;
        int maxPop;
        int maxIdx;
        int pop;
        clk = 1'b0;
        rstN = 1'b0;
        featValid = 1'b0;
        featData = '0;
        lcgState = 32'd24043;
        cycleCnt = 0;
        sentCount = 0;
        matchCount = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rstN = 1'b1;
        checkValue("busy", 32'(busy), 0);
        checkValue("predValid", 32'(predValid), 0);

        // All hidden bits are 1 for a zero frame, so scores are weight popcounts
        f = '0;
        zeroRef = predictRef(f);
        maxPop = 0;
        maxIdx = 0;
        for (int c = 0; c < harBnnPkg::CLASS_CNT; c++) begin
            pop = $countones(harBnnPkg::WEIGHTS1[c * harBnnPkg::HIDDEN_CNT +:
                                                 harBnnPkg::HIDDEN_CNT]);
            if (pop > maxPop) begin
                maxPop = pop;
                maxIdx = c;
            end
        end
        checkValue("all-zero reference topScore", 32'(zeroRef.topScore), maxPop);
        checkValue("all-zero reference classIdx", 32'(zeroRef.classIdx), maxIdx);
        sendFrame(f, 1'b0, 1'b0);
        f = {harBnnPkg::FEAT_CNT{4'hF}};
        sendFrame(f, 1'b0, 1'b0);
        waitDrain();

        for (int i = 0; i < RANDOM_FRAMES; i++) begin
            sendFrame(randomFrame(), 1'b1, 1'b0);
        end
        waitDrain();

        // Next frame starts on the cycle right after INFER
        for (int i = 0; i < BURST_FRAMES; i++) begin
            sendFrame(randomFrame(), 1'b0, 1'b0);
        end
        waitDrain();

        for (int i = 0; i < DROP_FRAMES; i++) begin
            sendFrame(randomFrame(), 1'b1, 1'b1);
        end
        waitDrain();

        // Partial frame, then reset
        f = randomFrame();
        for (int i = 0; i < 5; i++) begin
            driveCycle(1'b1, f[i]);
        end
        applyReset(3);
        checkValue("busy", 32'(busy), 0);
        checkValue("predValid", 32'(predValid), 0);
        sendFrame(randomFrame(), 1'b1, 1'b0);
        waitDrain();

        repeat (4) @(posedge clk);
        if (expQ.size() == 0 && matchCount == sentCount) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Only %0d of %0d predictions were matched", matchCount, sentCount);
            abortRun();
        end
    end

endmodule

// ==== hdl/harClassifier.sv ====
`timescale 1ns/1ps

module harClassifier (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             featValid,
    input  logic [harBnnPkg::FEAT_BITS-1:0]  featData,
    output logic                             busy,
    output logic                             predValid,
    output harBnnPkg::predictionT            prediction
);

    logic                            accept;
    logic                            frameClear;
    logic                            captureEn;
    logic                            lastFeat;
    logic [harBnnPkg::IDX_BITS-1:0]  index;
    harBnnPkg::featFrameT            frame;
    harBnnPkg::scoreVecT             scores;

    inferenceCtrl uInferenceCtrl (
        .clk        (clk),
        .rstN       (rstN),
        .featValid  (featValid),
        .lastFeat   (lastFeat),
        .accept     (accept),
        .frameClear (frameClear),
        .captureEn  (captureEn),
        .busy       (busy)
    );

    sampleCounter uSampleCounter (
        .clk        (clk),
        .rstN       (rstN),
        .accept     (accept),
        .frameClear (frameClear),
        .index      (index),
        .lastFeat   (lastFeat)
    );

    featureLoader uFeatureLoader (
        .clk      (clk),
        .rstN     (rstN),
        .accept   (accept),
        .featData (featData),
        .index    (index),
        .frame    (frame)
    );

    // Network evaluates the frame register with no pipeline stage
    bnnParser uBnnParser (
        .frame  (frame),
        .scores (scores)
    );

    argmaxSelect uArgmaxSelect (
        .clk        (clk),
        .rstN       (rstN),
        .scores     (scores),
        .captureEn  (captureEn),
        .prediction (prediction),
        .predValid  (predValid)
    );

endmodule

// ==== hdl/argmaxSelect.sv ====
`timescale 1ns/1ps

module argmaxSelect (
    input  logic                   clk,
    input  logic                   rstN,
    input  harBnnPkg::scoreVecT    scores,
    input  logic                   captureEn,
    output harBnnPkg::predictionT  prediction,
    output logic                   predValid
);

    logic [harBnnPkg::CLASS_BITS-1:0] bestIdx;
    logic [harBnnPkg::SUM_BITS-1:0]   bestScore;

    always_comb begin
        bestIdx = '0;
        bestScore = scores[0];
        for (int c = 1; c < harBnnPkg::CLASS_CNT; c++) begin
            if (scores[c] > bestScore) begin   // Strict compare keeps the lower index on ties
                bestIdx = harBnnPkg::CLASS_BITS'(c);
                bestScore = scores[c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            prediction <= '0;
            predValid <= 1'b0;
        end else begin
            predValid <= captureEn;
            if (captureEn) begin
                prediction.classIdx <= bestIdx;
                prediction.topScore <= bestScore;
            end
        end
    end

    singlePulse: assert property (
        @(posedge clk) disable iff (!rstN)
        predValid |=> !predValid
    ) else $error("argmaxSelect predValid held for two cycles");

    classInRange: assert property (
        @(posedge clk) disable iff (!rstN)
        predValid |-> (prediction.classIdx < harBnnPkg::CLASS_BITS'(harBnnPkg::CLASS_CNT))
    ) else $error("argmaxSelect class index %0d out of range", prediction.classIdx);

endmodule

// ==== hdl/bnnParser.sv ====
`timescale 1ns/1ps

module bnnParser (
    input  harBnnPkg::featFrameT frame,
    output harBnnPkg::scoreVecT  scores
);

    logic [harBnnPkg::HIDDEN_CNT-1:0] hidden;

    // Hidden layer
    for (genvar n = 0; n < harBnnPkg::HIDDEN_CNT; n++) begin : gNeuron
        logic signed [harBnnPkg::ACC_BITS-1:0] sum;
        logic        [harBnnPkg::ACC_BITS-1:0] featExt;

        always_comb begin
            sum = '0;
            featExt = '0;
            for (int f = 0; f < harBnnPkg::FEAT_CNT; f++) begin
                featExt = harBnnPkg::ACC_BITS'(frame[f]);  // Features are unsigned
                if (harBnnPkg::WEIGHTS0[n*harBnnPkg::FEAT_CNT + f]) begin
                    sum = sum + $signed(featExt);
                end else begin
                    sum = sum - $signed(featExt);
                end
            end
        end

        assign hidden[n] = (sum >= 0);
    end

    // Output layer does XNOR against class weights then popcount
    for (genvar c = 0; c < harBnnPkg::CLASS_CNT; c++) begin : gClass
        logic [harBnnPkg::HIDDEN_CNT-1:0] agree;
        logic [harBnnPkg::SUM_BITS-1:0]   popCount;

        assign agree = ~(hidden ^ harBnnPkg::WEIGHTS1[c*harBnnPkg::HIDDEN_CNT
                                                      +: harBnnPkg::HIDDEN_CNT]);

        always_comb begin
            popCount = '0;
            for (int h = 0; h < harBnnPkg::HIDDEN_CNT; h++) begin
                popCount = popCount + harBnnPkg::SUM_BITS'(agree[h]);
            end
        end

        assign scores[c] = popCount;
    end

endmodule

// ==== hdl/inferenceCtrl.sv ====
`timescale 1ns/1ps

module inferenceCtrl (
    input  logic clk,
    input  logic rstN,
    input  logic featValid,
    input  logic lastFeat,
    output logic accept,
    output logic frameClear,
    output logic captureEn,
    output logic busy
);

    harBnnPkg::ctrlStateT state;
    harBnnPkg::ctrlStateT nextState;
    logic loadEn;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= harBnnPkg::IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            harBnnPkg::IDLE: begin
                if (accept) begin
                    nextState = harBnnPkg::LOAD;
                end
            end
            harBnnPkg::LOAD: begin
                if (accept && lastFeat) begin
                    nextState = harBnnPkg::INFER;
                end
            end
            harBnnPkg::INFER: begin
                nextState = harBnnPkg::IDLE;   // Single evaluation cycle
            end
            default: begin
                nextState = harBnnPkg::IDLE;
            end
        endcase
    end

    // Features are only taken outside INFER
    assign loadEn = (state != harBnnPkg::INFER);
    assign accept = featValid && loadEn;

    assign frameClear = (state == harBnnPkg::INFER);
    assign captureEn = (state == harBnnPkg::INFER);
    assign busy = (state == harBnnPkg::INFER);

    inferOneCycle: assert property (
        @(posedge clk) disable iff (!rstN)
        (state == harBnnPkg::INFER) |=> (state != harBnnPkg::INFER)
    ) else $error("inferenceCtrl stayed in INFER");

endmodule

// ==== hdl/sampleCounter.sv ====
`timescale 1ns/1ps

module sampleCounter (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            accept,
    input  logic                            frameClear,
    output logic [harBnnPkg::IDX_BITS-1:0]  index,
    output logic                            lastFeat
);

    logic [harBnnPkg::IDX_BITS-1:0] count;

    always_ff @(posedge clk) begin
        if (!rstN || frameClear) begin
            count <= '0;
        end else if (accept) begin
            if (lastFeat) begin
                count <= '0;   // Wrap after the twelfth feature
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    assign index = count;
    assign lastFeat = (count == harBnnPkg::IDX_BITS'(harBnnPkg::FEAT_CNT - 1));

    countInRange: assert property (
        @(posedge clk) disable iff (!rstN)
        count <= harBnnPkg::IDX_BITS'(harBnnPkg::FEAT_CNT - 1)
    ) else $error("sampleCounter count %0d past last feature", count);

endmodule

// ==== hdl/featureLoader.sv ====
`timescale 1ns/1ps

module featureLoader (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              accept,
    input  logic [harBnnPkg::FEAT_BITS-1:0]   featData,
    input  logic [harBnnPkg::IDX_BITS-1:0]    index,
    output harBnnPkg::featFrameT              frame
);

    // Arrival order equals feature order, so the counter value picks the slot
    always_ff @(posedge clk) begin
        if (!rstN) begin
            frame <= '0;
        end else if (accept) begin
            frame[index] <= featData;
        end
    end

endmodule

// ==== hdl/harBnnPkg.sv ====
package harBnnPkg;

    localparam int FEAT_CNT = 12;
    localparam int FEAT_BITS = 4;
    localparam int HIDDEN_CNT = 40;
    localparam int CLASS_CNT = 6;
    localparam int SUM_BITS = $clog2(HIDDEN_CNT + 1);
    localparam int CLASS_BITS = $clog2(CLASS_CNT);
    localparam int IDX_BITS = $clog2(FEAT_CNT);            // Feature write index
    localparam int ACC_BITS = FEAT_BITS + $clog2(FEAT_CNT) + 1; // Signed neuron sum

    // Hidden layer weights with FEAT_CNT bits per neuron and neuron 0 in the low bits
    localparam logic [HIDDEN_CNT*FEAT_CNT-1:0] WEIGHTS0 = {
        8'b00110110,
        60'b0100110010_1101110001_1100101010_1111001011_1001110001_1010011010,
        60'b1001001111_0101100110_0001010001_0000011111_0100000001_1011101011,
        60'b0100011000_0001100100_0000011100_0011111110_0111001110_0110011110,
        60'b1010100011_1100000011_1100111110_1110100010_0111100110_0011010010,
        60'b0100011011_0111001011_1010110101_1111010011_1000111100_0000110000,
        60'b0000000100_1011110001_1001010101_1010001100_1101010001_0011010101,
        60'b0101111011_1110001110_0001011011_1000110001_0011100000_1000110000,
        50'b0101000000_1001000110_0000110111_1001100001_1010001110,
        2'b01
    };

    // Output layer weights with HIDDEN_CNT bits per class
    localparam logic [CLASS_CNT*HIDDEN_CNT-1:0] WEIGHTS1 = {
        2'b00,
        60'b1110011111_0110000010_1111100101_1000101000_1101011011_1111001010,
        60'b0101010110_1001110100_1110011111_0111100011_0101110000_1000101010,
        60'b0101000110_0110101011_0111001011_0100110101_1111110110_0000001100,
        58'b0110001111_1100000101_1100100100_0101000010_0111000011_11000100
    };

    // Element 0 is the first feature of the frame
    typedef logic [FEAT_CNT-1:0][FEAT_BITS-1:0] featFrameT;

    typedef logic [CLASS_CNT-1:0][SUM_BITS-1:0] scoreVecT;

    typedef struct packed {
        logic [CLASS_BITS-1:0] classIdx;
        logic [SUM_BITS-1:0]   topScore;
    } predictionT;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        INFER
    } ctrlStateT;

endpackage
